// File: src/fpu_pkg.sv
// FPU shared definitions
// Operation and funct3 codes, execute selects, sub-operations,
// FCLASS bit positions, canonical NaN and the FP word type
package fpu_pkg;

  // ==============================
  // Operation codes (fp_alu_op)
  // ==============================
  localparam logic [4:0] FP_SGNJ  = 5'b00101;
  localparam logic [4:0] FP_SGNJN = 5'b00110;
  localparam logic [4:0] FP_SGNJX = 5'b00111;
  localparam logic [4:0] FP_MIN   = 5'b01000;
  localparam logic [4:0] FP_MAX   = 5'b01001;
  localparam logic [4:0] FP_CMP   = 5'b01011;
  localparam logic [4:0] FP_CLASS = 5'b01100;
  localparam logic [4:0] FP_MV_XW = 5'b10001; // FP bits to integer side
  localparam logic [4:0] FP_MV_WX = 5'b10010; // Integer bits to FP side

  // Compare flavour, straight from the instruction
  localparam logic [2:0] F3_FEQ = 3'b010;
  localparam logic [2:0] F3_FLT = 3'b001;
  localparam logic [2:0] F3_FLE = 3'b000;

  // ==============================
  // Execute selects
  // ==============================
  localparam logic [2:0] SEL_SIGN   = 3'd0;
  localparam logic [2:0] SEL_MINMAX = 3'd1;
  localparam logic [2:0] SEL_CMP    = 3'd2;
  localparam logic [2:0] SEL_CLASS  = 3'd3;
  localparam logic [2:0] SEL_MV_XW  = 3'd4;
  localparam logic [2:0] SEL_MV_WX  = 3'd5;

  // Sub-operation, meaning depends on the select
  localparam logic [1:0] SUB_SGNJ  = 2'd0; // Copy sign of b
  localparam logic [1:0] SUB_SGNJN = 2'd1; // Inverted sign of b
  localparam logic [1:0] SUB_SGNJX = 2'd2; // Xor of both signs
  localparam logic [1:0] SUB_MIN   = 2'd0;
  localparam logic [1:0] SUB_MAX   = 2'd1;
  localparam logic [1:0] SUB_EQ    = 2'd0;
  localparam logic [1:0] SUB_LT    = 2'd1;
  localparam logic [1:0] SUB_LE    = 2'd2;

  // ==============================
  // FCLASS mask bit positions
  // ==============================
  localparam int CLASS_W      = 10;
  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

  // Canonical quiet NaN for single precision
  localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

  // One FP register word, seen as raw bits or as IEEE fields
  typedef union packed {
    logic [31:0] bits;            // Moves, sign injection
    struct packed {
      logic        sign;
      logic [7:0]  exp;           // Biased exponent
      logic [22:0] man;           // Fraction, bit 22 is the quiet bit
    } f;
  } fp_word_u;

endpackage

// File: src/fpu_decode.sv
// FPU operation decoder
// Maps fp_alu_op and funct3 onto an execute select and sub-operation,
// and qualifies start with a supported code
`timescale 1ns/1ps

module fpu_decode import fpu_pkg::*; (
  input  logic       start,
  input  logic [4:0] fp_alu_op,
  input  logic [2:0] funct3,
  output logic       op_valid,
  output logic [2:0] exec_sel,
  output logic [1:0] sub_op
);

  logic supported; // Code is one of the single-cycle ops

  always_comb begin
    supported = 1'b1;
    exec_sel  = SEL_SIGN;
    sub_op    = SUB_SGNJ;
    case (fp_alu_op)
      FP_SGNJ: begin
        exec_sel = SEL_SIGN;
        sub_op   = SUB_SGNJ;
      end
      FP_SGNJN: begin
        exec_sel = SEL_SIGN;
        sub_op   = SUB_SGNJN;
      end
      FP_SGNJX: begin
        exec_sel = SEL_SIGN;
        sub_op   = SUB_SGNJX;
      end
      FP_MIN: begin
        exec_sel = SEL_MINMAX;
        sub_op   = SUB_MIN;
      end
      FP_MAX: begin
        exec_sel = SEL_MINMAX;
        sub_op   = SUB_MAX;
      end
      FP_CMP: begin
        exec_sel = SEL_CMP;
        case (funct3)
          F3_FEQ:  sub_op = SUB_EQ;
          F3_FLT:  sub_op = SUB_LT;
          F3_FLE:  sub_op = SUB_LE;
          default: sub_op = SUB_EQ; // Odd funct3 behaves as FEQ
        endcase
      end
      FP_CLASS: exec_sel = SEL_CLASS;
      FP_MV_XW: exec_sel = SEL_MV_XW;
      FP_MV_WX: exec_sel = SEL_MV_WX;
      default:  supported = 1'b0; // Multi-cycle or illegal, ignored here
    endcase
  end

  // Only this strobe lets a result through
  assign op_valid = start & supported;

endmodule

// File: src/fpu_classify.sv
// FCLASS logic for one single-precision operand
// Sets exactly one bit of the ten-bit mask, in RISC-V FCLASS order
`timescale 1ns/1ps

module fpu_classify import fpu_pkg::*; (
  input  fp_word_u             operand,
  output logic [CLASS_W-1:0]   class_mask
);

  logic exp_ones;  // Inf or NaN
  logic exp_zero;  // Zero or subnormal
  logic man_zero;
  logic neg;

  assign exp_ones = &operand.f.exp;
  assign exp_zero = ~|operand.f.exp;
  assign man_zero = ~|operand.f.man;
  assign neg      = operand.f.sign;

  always_comb begin
    class_mask = '0;
    if (exp_ones) begin
      if (man_zero) begin
        // Infinity
        if (neg) class_mask[CLS_NEG_INF] = 1'b1;
        else     class_mask[CLS_POS_INF] = 1'b1;
      end else if (operand.f.man[22]) begin
        class_mask[CLS_QNAN] = 1'b1;      // Quiet bit set
      end else begin
        class_mask[CLS_SNAN] = 1'b1;      // Signalling, payload non-zero
      end
    end else if (exp_zero) begin
      if (man_zero) begin
        if (neg) class_mask[CLS_NEG_ZERO] = 1'b1;
        else     class_mask[CLS_POS_ZERO] = 1'b1;
      end else begin
        // Subnormal
        if (neg) class_mask[CLS_NEG_SUB] = 1'b1;
        else     class_mask[CLS_POS_SUB] = 1'b1;
      end
    end else begin
      // Normal number
      if (neg) class_mask[CLS_NEG_NORM] = 1'b1;
      else     class_mask[CLS_POS_NORM] = 1'b1;
    end
  end

endmodule

// File: src/fpu_execute.sv
// FPU single-cycle execute datapath
// Sign injection, min/max, compare, classify and the two bit moves.
// Purely combinational, the result stage picks up fp_res, int_res, nv
`timescale 1ns/1ps

module fpu_execute import fpu_pkg::*; (
  input  logic [2:0]  exec_sel,
  input  logic [1:0]  sub_op,
  input  fp_word_u    operand_a,
  input  fp_word_u    operand_b,
  input  logic [31:0] int_operand,
  output fp_word_u    fp_res,
  output logic [31:0] int_res,
  output logic        nv
);

  logic [CLASS_W-1:0] cls_a;
  logic [CLASS_W-1:0] cls_b;

  fpu_classify u_class_a (
    .operand    (operand_a),
    .class_mask (cls_a)
  );

  fpu_classify u_class_b (
    .operand    (operand_b),
    .class_mask (cls_b)
  );

  // ==============================
  // Operand properties
  // ==============================
  logic a_nan, b_nan, a_snan, b_snan;
  logic any_nan, any_snan;
  logic both_zero;
  logic mag_lt, mag_gt;  // Magnitude order, sign ignored
  logic a_lt_b;          // Numeric less-than, zeros equal
  logic a_eq_b;
  logic a_below_b;       // Like a_lt_b but -0 sorts under +0

  assign a_nan    = cls_a[CLS_SNAN] | cls_a[CLS_QNAN];
  assign b_nan    = cls_b[CLS_SNAN] | cls_b[CLS_QNAN];
  assign a_snan   = cls_a[CLS_SNAN];
  assign b_snan   = cls_b[CLS_SNAN];
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_snan | b_snan;
  assign both_zero = (cls_a[CLS_NEG_ZERO] | cls_a[CLS_POS_ZERO]) &
                     (cls_b[CLS_NEG_ZERO] | cls_b[CLS_POS_ZERO]);

  assign mag_lt = operand_a.bits[30:0] < operand_b.bits[30:0];
  assign mag_gt = operand_a.bits[30:0] > operand_b.bits[30:0];

  always_comb begin
    if (both_zero)
      a_lt_b = 1'b0;                              // +0 == -0
    else if (operand_a.f.sign != operand_b.f.sign)
      a_lt_b = operand_a.f.sign;                  // Negative side is smaller
    else if (!operand_a.f.sign)
      a_lt_b = mag_lt;
    else
      a_lt_b = mag_gt;                            // Both negative, order flips
  end

  assign a_eq_b    = both_zero | (operand_a.bits == operand_b.bits);
  assign a_below_b = both_zero ? (operand_a.f.sign & ~operand_b.f.sign) : a_lt_b;

  // ==============================
  // Result select
  // ==============================
  always_comb begin
    fp_res.bits = '0;
    int_res     = '0;
    nv          = 1'b0;
    case (exec_sel)
      SEL_SIGN: begin
        fp_res.bits = operand_a.bits;             // Magnitude always from a
        case (sub_op)
          SUB_SGNJN: fp_res.f.sign = ~operand_b.f.sign;
          SUB_SGNJX: fp_res.f.sign = operand_a.f.sign ^ operand_b.f.sign;
          default:   fp_res.f.sign = operand_b.f.sign;
        endcase
      end
      SEL_MINMAX: begin
        nv = any_snan;                            // Quiet NaN alone is fine
        if (a_nan && b_nan)
          fp_res.bits = CANON_NAN;
        else if (a_nan)
          fp_res = operand_b;
        else if (b_nan)
          fp_res = operand_a;
        else if (sub_op == SUB_MAX)
          fp_res = a_below_b ? operand_b : operand_a;
        else
          fp_res = a_below_b ? operand_a : operand_b;
      end
      SEL_CMP: begin
        case (sub_op)
          SUB_LT: begin
            int_res[0] = ~any_nan & a_lt_b;
            nv         = any_nan;                 // Signalling compare
          end
          SUB_LE: begin
            int_res[0] = ~any_nan & (a_lt_b | a_eq_b);
            nv         = any_nan;
          end
          default: begin
            int_res[0] = ~any_nan & a_eq_b;       // Quiet compare
            nv         = any_snan;
          end
        endcase
      end
      SEL_CLASS: int_res = {{(32-CLASS_W){1'b0}}, cls_a};
      SEL_MV_XW: int_res = operand_a.bits;        // Raw bits, no conversion
      SEL_MV_WX: fp_res.bits = int_operand;
      default: begin
        fp_res.bits = '0;                         // Unused select codes
      end
    endcase
  end

endmodule

// File: src/fpu_result.sv
// FPU result stage
// Captures the execute outputs on an accepted operation and holds
// them until the next one. done pulses one cycle after op_valid
`timescale 1ns/1ps

module fpu_result import fpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        op_valid,
  input  fp_word_u    fp_res,
  input  logic [31:0] int_res,
  input  logic        nv,
  output fp_word_u    fp_result,
  output logic [31:0] int_result,
  output logic        flag_nv,
  output logic        done
);

  // ==============================
  // Output registers
  // ==============================
  always_ff @(posedge clk) begin
    if (rst) begin
      fp_result.bits <= '0;
      int_result     <= '0;
      flag_nv        <= 1'b0;
      done           <= 1'b0;
    end else begin
      done <= op_valid;                // One-cycle pulse per accepted op
      if (op_valid) begin
        fp_result  <= fp_res;
        int_result <= int_res;
        flag_nv    <= nv;              // Invalid flag of this op only
      end
    end
  end

endmodule

// File: src/fpu_top.sv
// Single-cycle FPU top level (RV32F subset)
// Sign injection, min/max, compare, classify and bit moves.
// Results and flag_nv appear one cycle after start, with a done pulse
`timescale 1ns/1ps

module fpu_top import fpu_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        start,        // Issue strobe, one op per cycle
  input  logic [4:0]  fp_alu_op,
  input  logic [2:0]  funct3,       // Compare flavour
  input  fp_word_u    operand_a,    // rs1
  input  fp_word_u    operand_b,    // rs2
  input  logic [31:0] int_operand,  // Source for FMV.W.X
  output fp_word_u    fp_result,
  output logic [31:0] int_result,
  output logic        flag_nv,
  output logic        done
);

  logic        op_valid;
  logic [2:0]  exec_sel;
  logic [1:0]  sub_op;
  fp_word_u    fp_res;
  logic [31:0] int_res;
  logic        nv;

  fpu_decode u_decode (
    .start     (start),
    .fp_alu_op (fp_alu_op),
    .funct3    (funct3),
    .op_valid  (op_valid),
    .exec_sel  (exec_sel),
    .sub_op    (sub_op)
  );

  fpu_execute u_execute (
    .exec_sel    (exec_sel),
    .sub_op      (sub_op),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .fp_res      (fp_res),
    .int_res     (int_res),
    .nv          (nv)
  );

  fpu_result u_result (
    .clk        (clk),
    .rst        (rst),
    .op_valid   (op_valid),
    .fp_res     (fp_res),
    .int_res    (int_res),
    .nv         (nv),
    .fp_result  (fp_result),
    .int_result (int_result),
    .flag_nv    (flag_nv),
    .done       (done)
  );

endmodule

// File: bench/fpu_chk.sv
// FPU protocol checker
// Bound to the top level; watches done against reset, accepted
// starts and output stability
`timescale 1ns/1ps

module fpu_chk import fpu_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        start,
  input logic [4:0]  fp_alu_op,
  input fp_word_u    fp_result,
  input logic [31:0] int_result,
  input logic        flag_nv,
  input logic        done
);

  int unsigned assert_fails = 0; // Failed assertion count

  logic accepted; // Start with a code this unit executes
  assign accepted = start && (fp_alu_op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN,
                                               FP_MAX, FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX});

  // Reset keeps done low, including the cycle after release
  a_reset_done: assert property (@(posedge clk) rst |=> !done)
    else begin
      assert_fails++;
      $error("done high during or right after reset");
    end

  a_done_follows: assert property (@(posedge clk) disable iff (rst) accepted |=> done)
    else begin
      assert_fails++;
      $error("accepted start not followed by done");
    end

  // No stretched pulse without a fresh start
  a_single_pulse: assert property (@(posedge clk) disable iff (rst)
    done && !accepted |=> !done)
    else begin
      assert_fails++;
      $error("done high two cycles without a start");
    end

  a_hold_outputs: assert property (@(posedge clk) disable iff (rst)
    !done |-> $stable(fp_result) && $stable(int_result) && $stable(flag_nv))
    else begin
      assert_fails++;
      $error("results changed while done is low");
    end

endmodule

bind fpu_top fpu_chk u_chk (
  .clk        (clk),
  .rst        (rst),
  .start      (start),
  .fp_alu_op  (fp_alu_op),
  .fp_result  (fp_result),
  .int_result (int_result),
  .flag_nv    (flag_nv),
  .done       (done)
);

// File: bench/fpu_tb.sv
// FPU testbench
// Table of directed rows plus LCG random sign-injection and move rows,
// run once with idle gaps and once back to back, then an illegal opcode
`timescale 1ns/1ps

module fpu_tb import fpu_pkg::*; ();

  localparam int N_RAND = 20; // Random rows appended to the table

  logic        clk;
  logic        rst;
  logic        start;
  logic [4:0]  fp_alu_op;
  logic [2:0]  funct3;
  fp_word_u    operand_a;
  fp_word_u    operand_b;
  logic [31:0] int_operand;
  fp_word_u    fp_result;
  logic [31:0] int_result;
  logic        flag_nv;
  logic        done;

  // ==============================
  // Stimulus table with one index per row
  // ==============================
  string       t_name[$];
  logic [4:0]  t_op[$];
  logic [2:0]  t_f3[$];
  logic [31:0] t_a[$];
  logic [31:0] t_b[$];
  logic [31:0] t_int[$];
  logic [31:0] t_exp_fp[$];
  logic [31:0] t_exp_int[$];
  logic        t_exp_nv[$];

  int          value_errs = 0;
  int          proto_errs = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;  // Set once the table is built
  logic [31:0] lcg_state;

  fpu_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("Timeout: run passed %0d cycles without completing", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic add_row(input string name, input logic [4:0] op, input logic [2:0] f3,
                         input logic [31:0] a, b, iop, exp_fp, exp_int, input logic exp_nv);
    t_name.push_back(name);
    t_op.push_back(op);
    t_f3.push_back(f3);
    t_a.push_back(a);
    t_b.push_back(b);
    t_int.push_back(iop);
    t_exp_fp.push_back(exp_fp);
    t_exp_int.push_back(exp_int);
    t_exp_nv.push_back(exp_nv);
  endtask

  task automatic build_table();
    logic [31:0] a, b, iop;
    // Sign injection keeps the magnitude of a
    add_row("sgnj_pos_neg", FP_SGNJ, 3'd0, 32'h3f800000, 32'hc0000000, 0, 32'hbf800000, 0, 0);
    add_row("sgnjn_pos_neg", FP_SGNJN, 3'd0, 32'h3f800000, 32'hc0000000, 0, 32'h3f800000, 0, 0);
    add_row("sgnjx_neg_neg", FP_SGNJX, 3'd0, 32'hbfc00000, 32'hc0000000, 0, 32'h3fc00000, 0, 0);
    add_row("sgnj_snan_raw", FP_SGNJ, 3'd0, 32'h7f800001, 32'h80000000, 0, 32'hff800001, 0, 0);
    // Min/max
    add_row("min_ordinary", FP_MIN, 3'd0, 32'h40000000, 32'h3f800000, 0, 32'h3f800000, 0, 0);
    add_row("max_ordinary", FP_MAX, 3'd0, 32'h40000000, 32'h3f800000, 0, 32'h40000000, 0, 0);
    add_row("min_negative", FP_MIN, 3'd0, 32'hbf800000, 32'hc0000000, 0, 32'hc0000000, 0, 0);
    add_row("min_zeros", FP_MIN, 3'd0, 32'h80000000, 32'h00000000, 0, 32'h80000000, 0, 0);
    add_row("max_zeros", FP_MAX, 3'd0, 32'h80000000, 32'h00000000, 0, 32'h00000000, 0, 0);
    add_row("min_qnan_a", FP_MIN, 3'd0, 32'h7fc00000, 32'h3f800000, 0, 32'h3f800000, 0, 0);
    add_row("max_qnan_b", FP_MAX, 3'd0, 32'hc0000000, 32'h7fc00000, 0, 32'hc0000000, 0, 0);
    add_row("min_two_qnan", FP_MIN, 3'd0, 32'h7fc00000, 32'hffc00001, 0, CANON_NAN, 0, 0);
    add_row("max_snan", FP_MAX, 3'd0, 32'h7f800001, 32'h40000000, 0, 32'h40000000, 0, 1);
    add_row("min_snan_qnan", FP_MIN, 3'd0, 32'h7fc00000, 32'h7fa00000, 0, CANON_NAN, 0, 1);
    add_row("max_neg_inf", FP_MAX, 3'd0, 32'hff800000, 32'h42c80000, 0, 32'h42c80000, 0, 0);
    // Compare result lands in bit 0 of int_result
    add_row("feq_equal", FP_CMP, F3_FEQ, 32'h3f800000, 32'h3f800000, 0, 0, 1, 0);
    add_row("feq_differ", FP_CMP, F3_FEQ, 32'h3f800000, 32'h40000000, 0, 0, 0, 0);
    add_row("flt_true", FP_CMP, F3_FLT, 32'hc0000000, 32'h3f800000, 0, 0, 1, 0);
    add_row("flt_false", FP_CMP, F3_FLT, 32'h40000000, 32'h3f800000, 0, 0, 0, 0);
    add_row("fle_equal", FP_CMP, F3_FLE, 32'h40000000, 32'h40000000, 0, 0, 1, 0);
    add_row("fle_negative", FP_CMP, F3_FLE, 32'hbf800000, 32'hc0000000, 0, 0, 0, 0);
    add_row("feq_zeros", FP_CMP, F3_FEQ, 32'h00000000, 32'h80000000, 0, 0, 1, 0);
    add_row("flt_zeros", FP_CMP, F3_FLT, 32'h80000000, 32'h00000000, 0, 0, 0, 0);
    add_row("fle_zeros", FP_CMP, F3_FLE, 32'h80000000, 32'h00000000, 0, 0, 1, 0);
    add_row("feq_qnan", FP_CMP, F3_FEQ, 32'h7fc00000, 32'h3f800000, 0, 0, 0, 0);
    add_row("flt_qnan", FP_CMP, F3_FLT, 32'h3f800000, 32'h7fc00000, 0, 0, 0, 1);
    add_row("fle_qnan", FP_CMP, F3_FLE, 32'h7fc00000, 32'h7fc00000, 0, 0, 0, 1);
    add_row("feq_snan", FP_CMP, F3_FEQ, 32'h7f800001, 32'h3f800000, 0, 0, 0, 1);
    add_row("flt_snan", FP_CMP, F3_FLT, 32'h3f800000, 32'h7fa00000, 0, 0, 0, 1);
    add_row("fle_snan", FP_CMP, F3_FLE, 32'h7f800001, 32'h7f800001, 0, 0, 0, 1);
    // Classify with one operand per class in FCLASS bit order
    add_row("class_neg_inf", FP_CLASS, 3'd0, 32'hff800000, 0, 0, 0, 32'h001, 0);
    add_row("class_neg_norm", FP_CLASS, 3'd0, 32'hc2c80000, 0, 0, 0, 32'h002, 0);
    add_row("class_neg_sub", FP_CLASS, 3'd0, 32'h80400000, 0, 0, 0, 32'h004, 0);
    add_row("class_neg_zero", FP_CLASS, 3'd0, 32'h80000000, 0, 0, 0, 32'h008, 0);
    add_row("class_pos_zero", FP_CLASS, 3'd0, 32'h00000000, 0, 0, 0, 32'h010, 0);
    add_row("class_pos_sub", FP_CLASS, 3'd0, 32'h00000001, 0, 0, 0, 32'h020, 0);
    add_row("class_pos_norm", FP_CLASS, 3'd0, 32'h42c80000, 0, 0, 0, 32'h040, 0);
    add_row("class_pos_inf", FP_CLASS, 3'd0, 32'h7f800000, 0, 0, 0, 32'h080, 0);
    add_row("class_snan", FP_CLASS, 3'd0, 32'h7f800001, 0, 0, 0, 32'h100, 0);
    add_row("class_qnan", FP_CLASS, 3'd0, 32'h7fc00000, 0, 0, 0, 32'h200, 0);
    // Moves
    add_row("mv_x_w", FP_MV_XW, 3'd0, 32'hc0490fdb, 0, 0, 0, 32'hc0490fdb, 0);
    add_row("mv_w_x", FP_MV_WX, 3'd0, 0, 0, 32'h3f800000, 32'h3f800000, 0, 0);
    // Random rows checked against the sign and move rules
    for (int k = 0; k < N_RAND; k++) begin
      a   = next_rand();
      b   = next_rand();
      iop = next_rand();
      case ((next_rand() >> 16) % 5)  // Upper LCG bits are the better ones
        0: add_row($sformatf("rand_sgnj_%0d", k), FP_SGNJ, 3'd0, a, b, iop,
                   {b[31], a[30:0]}, 0, 0);
        1: add_row($sformatf("rand_sgnjn_%0d", k), FP_SGNJN, 3'd0, a, b, iop,
                   {~b[31], a[30:0]}, 0, 0);
        2: add_row($sformatf("rand_sgnjx_%0d", k), FP_SGNJX, 3'd0, a, b, iop,
                   {a[31] ^ b[31], a[30:0]}, 0, 0);
        3: add_row($sformatf("rand_mv_x_w_%0d", k), FP_MV_XW, 3'd0, a, b, iop, 0, a, 0);
        default: add_row($sformatf("rand_mv_w_x_%0d", k), FP_MV_WX, 3'd0, a, b, iop, iop, 0, 0);
      endcase
    end
  endtask

  // ==============================
  // Compare tasks
  // ==============================
  task automatic check_fp_word(input string name, input fp_word_u exp_v, input fp_word_u act);
    if (act.bits !== exp_v.bits) begin
      value_errs++;
      $display("[FAIL] %s fp_result expected %h actual %h", name, exp_v.bits, act.bits);
    end
  endtask

  task automatic verify_int_word(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act);
    if (act !== exp_v) begin
      value_errs++;
      $display("[FAIL] %s int_result expected %h actual %h", name, exp_v, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_v, input logic act);
    if (act !== exp_v) begin
      value_errs++;
      $display("[FAIL] %s flag_nv expected %b actual %b", name, exp_v, act);
    end
  endtask

  task automatic check_row(input string name, input int i);
    check_fp_word(name, t_exp_fp[i], fp_result);
    verify_int_word(name, t_exp_int[i], int_result);
    compare_flag(name, t_exp_nv[i], flag_nv);
  endtask

  task automatic drive_row(input int i);
    start          = 1'b1;
    fp_alu_op      = t_op[i];
    funct3         = t_f3[i];
    operand_a.bits = t_a[i];
    operand_b.bits = t_b[i];
    int_operand    = t_int[i];
  endtask

  task automatic wait_for_done(input string name);
    int n;
    n = 0;
    while (done !== 1'b1 && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (done !== 1'b1) begin
      proto_errs++;
      $display("No done pulse for %s within 4 cycles", name);
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    rst            = 1'b1;
    start          = 1'b0;
    fp_alu_op      = '0;
    funct3         = '0;
    operand_a.bits = '0;
    operand_b.bits = '0;
    int_operand    = '0;
    lcg_state      = 32'hc46d;
    build_table();
    cycle_limit = t_name.size() * 4 + 50;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (done !== 1'b0) begin
      proto_errs++;
      $display("done is high right after reset");
    end
    // One row at a time with an idle cycle between
    for (int i = 0; i < t_name.size(); i++) begin
      drive_row(i);
      @(negedge clk);
      start = 1'b0;
      wait_for_done(t_name[i]);
      check_row(t_name[i], i);
      @(negedge clk);
    end
    // Same rows on consecutive cycles with each result one cycle later
    for (int i = 0; i <= t_name.size(); i++) begin
      if (i > 0) begin
        if (done !== 1'b1) begin
          proto_errs++;
          $display("Missing done in back-to-back issue of %s", t_name[i-1]);
        end
        check_row({"b2b_", t_name[i-1]}, i - 1);
      end
      if (i < t_name.size())
        drive_row(i);
      else
        start = 1'b0;
      @(negedge clk);
    end
    // FADD code is not part of this unit and must be ignored
    start          = 1'b1;
    fp_alu_op      = 5'b00000;
    operand_a.bits = 32'h3f800000;
    repeat (3) begin
      @(negedge clk);
      if (done !== 1'b0) begin
        proto_errs++;
        $display("done pulsed for an unsupported opcode");
      end
    end
    start = 1'b0;
    check_row("unsupported_hold", t_name.size() - 1);  // Last row's results still held
    $display("Errors: %0d value, %0d protocol, %0d assertion",
             value_errs, proto_errs, i_dut.u_chk.assert_fails);
    if (value_errs + proto_errs + i_dut.u_chk.assert_fails == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// File: project.f
src/fpu_pkg.sv
src/fpu_decode.sv
src/fpu_classify.sv
src/fpu_execute.sv
src/fpu_result.sv
src/fpu_top.sv
bench/fpu_chk.sv
bench/fpu_tb.sv

// File: Bender.yml
package:
  name: fpu_single_cycle

sources:
  - src/fpu_pkg.sv
  - src/fpu_decode.sv
  - src/fpu_classify.sv
  - src/fpu_execute.sv
  - src/fpu_result.sv
  - src/fpu_top.sv
  - target: simulation
    files:
      - bench/fpu_chk.sv
      - bench/fpu_tb.sv
